// File: common/mem_pkg.sv
package mem_pkg;

  localparam int XLEN    = 64;
  localparam int REGNO_W = 5;
  localparam int OP_W    = 4;
  localparam int STRB_W  = XLEN / 8;

  localparam logic [OP_W-1:0] OP_NONE = 4'd0;
  localparam logic [OP_W-1:0] OP_LB   = 4'd1;
  localparam logic [OP_W-1:0] OP_LBU  = 4'd2;
  localparam logic [OP_W-1:0] OP_LH   = 4'd3;
  localparam logic [OP_W-1:0] OP_LHU  = 4'd4;
  localparam logic [OP_W-1:0] OP_LW   = 4'd5;
  localparam logic [OP_W-1:0] OP_LWU  = 4'd6;
  localparam logic [OP_W-1:0] OP_LD   = 4'd7;
  localparam logic [OP_W-1:0] OP_SB   = 4'd8;
  localparam logic [OP_W-1:0] OP_SH   = 4'd9;
  localparam logic [OP_W-1:0] OP_SW   = 4'd10;
  localparam logic [OP_W-1:0] OP_SD   = 4'd11;

  // Single level paging
  localparam int PAGE_BITS     = 12;
  localparam int PT_INDEX_BITS = 10;
  localparam int PPN_W         = 44;
  localparam int VPN_W         = XLEN - PAGE_BITS;
  localparam int TLB_ENTRIES   = 8;
  localparam int TLB_IDX_W     = $clog2(TLB_ENTRIES);
  localparam int TLB_TAG_W     = VPN_W - TLB_IDX_W;

  // One doubleword per line
  localparam int CACHE_LINES = 64;
  localparam int LINE_OFF_W  = 3;
  localparam int CACHE_IDX_W = $clog2(CACHE_LINES);
  localparam int CACHE_TAG_W = XLEN - CACHE_IDX_W - LINE_OFF_W;

  localparam int STATE_W = 2;
  localparam logic [STATE_W-1:0] ST_IDLE      = 2'd0;
  localparam logic [STATE_W-1:0] ST_TRANSLATE = 2'd1;
  localparam logic [STATE_W-1:0] ST_ACCESS    = 2'd2;

  typedef union packed {
    logic [XLEN-1:0] data;
    struct packed {
      logic [9:0]       rsvd_hi;
      logic [PPN_W-1:0] ppn;      // Bits 53:10
      logic [8:0]       rsvd_lo;
      logic             valid;
    } pte;
  } mem_word_u;

endpackage

// File: mem_stage/lsu_align.sv
module lsu_align import mem_pkg::*; (
  input  logic [OP_W-1:0]   op,
  input  logic [2:0]        offset,
  input  logic [XLEN-1:0]   rdata,
  input  logic [XLEN-1:0]   wdata,
  output logic [XLEN-1:0]   mdata,
  output logic [XLEN-1:0]   wdata_lanes,
  output logic [STRB_W-1:0] strb
);

  logic [XLEN-1:0] byte_sh;
  logic [XLEN-1:0] half_sh;
  logic [XLEN-1:0] word_sh;

  // Low offset bits dropped for wider accesses
  assign byte_sh = rdata >> {offset, 3'b000};
  assign half_sh = rdata >> {offset[2:1], 4'b0000};
  assign word_sh = rdata >> {offset[2], 5'b00000};

  always_comb begin
    mdata       = '0;
    wdata_lanes = wdata;
    strb        = '0;
    case (op)
      OP_LB:  mdata = {{(XLEN-8){byte_sh[7]}}, byte_sh[7:0]};
      OP_LBU: mdata = {{(XLEN-8){1'b0}}, byte_sh[7:0]};
      OP_LH:  mdata = {{(XLEN-16){half_sh[15]}}, half_sh[15:0]};
      OP_LHU: mdata = {{(XLEN-16){1'b0}}, half_sh[15:0]};
      OP_LW:  mdata = {{(XLEN-32){word_sh[31]}}, word_sh[31:0]};
      OP_LWU: mdata = {{(XLEN-32){1'b0}}, word_sh[31:0]};
      OP_LD:  mdata = rdata;
      OP_SB: begin
        wdata_lanes = {STRB_W{wdata[7:0]}};
        strb        = 8'b0000_0001 << offset;
      end
      OP_SH: begin
        wdata_lanes = {(XLEN/16){wdata[15:0]}};
        strb        = 8'b0000_0011 << {offset[2:1], 1'b0};
      end
      OP_SW: begin
        wdata_lanes = {(XLEN/32){wdata[31:0]}};
        strb        = 8'b0000_1111 << {offset[2], 2'b00};
      end
      OP_SD: begin
        strb = 8'hff;
      end
      default: mdata = '0;
    endcase
  end

endmodule

// File: mem_stage/mem_stage.sv
module mem_stage import mem_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               flush,
  input  logic               in_valid,
  output logic               in_ready,
  input  logic [OP_W-1:0]    in_op,
  input  logic [XLEN-1:0]    in_addr,
  input  logic [XLEN-1:0]    in_wdata,
  input  logic [REGNO_W-1:0] in_rd_regno,
  input  logic               in_update_rd,
  output logic               out_valid,
  output logic [XLEN-1:0]    out_mdata,
  output logic [REGNO_W-1:0] out_rd_regno,
  output logic               out_update_rd,
  output logic               tlb_lookup,
  output logic [XLEN-1:0]    tlb_vaddr,
  input  logic               tlb_done,
  input  logic [XLEN-1:0]    tlb_paddr,
  output logic               cache_req,
  output logic               cache_we,
  output logic [XLEN-1:0]    cache_paddr,
  output logic [XLEN-1:0]    cache_wdata,
  output logic [STRB_W-1:0]  cache_strb,
  input  logic               cache_done,
  input  logic [XLEN-1:0]    cache_rdata
);

  logic [STATE_W-1:0] state;
  logic [OP_W-1:0]    op_q;
  logic [2:0]         off_q;
  logic [XLEN-1:0]    wdata_q;
  logic [REGNO_W-1:0] regno_q;
  logic               update_q;
  logic [XLEN-1:0]    load_value;
  logic               accept;

  assign in_ready    = (state == ST_IDLE);
  assign accept      = in_valid && in_ready;
  assign tlb_lookup  = accept && (in_op != OP_NONE);
  assign tlb_vaddr   = {in_addr[XLEN-1:3], 3'b000};  // Doubleword address
  assign cache_req   = (state == ST_TRANSLATE) && tlb_done;
  assign cache_we    = op_q inside {OP_SB, OP_SH, OP_SW, OP_SD};
  assign cache_paddr = tlb_paddr;

  lsu_align u_align (
    .op          (op_q),
    .offset      (off_q),
    .rdata       (cache_rdata),
    .wdata       (wdata_q),
    .mdata       (load_value),
    .wdata_lanes (cache_wdata),
    .strb        (cache_strb)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept && (in_op == OP_NONE)) begin
            out_valid <= 1'b1;  // Nothing to translate
          end else if (accept) begin
            state <= ST_TRANSLATE;
          end
        end
        ST_TRANSLATE: begin
          if (tlb_done) begin
            state <= ST_ACCESS;  // Cache request went out this cycle
          end
        end
        ST_ACCESS: begin
          if (cache_done) begin
            state     <= ST_IDLE;
            out_valid <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q     <= in_op;
      off_q    <= in_addr[2:0];
      wdata_q  <= in_wdata;
      regno_q  <= in_rd_regno;
      update_q <= in_update_rd;
    end
    if (accept && (in_op == OP_NONE)) begin
      out_mdata     <= '0;
      out_rd_regno  <= in_rd_regno;
      out_update_rd <= in_update_rd;
    end else if ((state == ST_ACCESS) && cache_done) begin
      out_mdata     <= load_value;  // Zero for stores
      out_rd_regno  <= regno_q;
      out_update_rd <= update_q;
    end
  end

  // TLB entries may only be dropped between operations
  a_flush_idle: assert property (@(posedge clk) disable iff (reset) !in_ready |-> !flush);

  a_done_busy: assert property (
    @(posedge clk) disable iff (reset) (state == ST_IDLE) |-> !tlb_done
  );

endmodule

// File: dtlb/dtlb.sv
module dtlb import mem_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            flush,
  input  logic [XLEN-1:0] ptbr,
  input  logic            lookup,
  input  logic [XLEN-1:0] vaddr,
  output logic            done,
  output logic [XLEN-1:0] paddr,
  output logic            req_valid,
  output logic [XLEN-1:0] req_addr,
  input  logic            resp_valid,
  input  mem_word_u       resp_data
);

  logic [TLB_ENTRIES-1:0] valid;
  logic [TLB_TAG_W-1:0]   tag_mem [TLB_ENTRIES];
  logic [PPN_W-1:0]       ppn_mem [TLB_ENTRIES];
  logic [VPN_W-1:0]       vpn;
  logic [TLB_IDX_W-1:0]   idx;
  logic                   hit;
  logic                   walking;
  logic [VPN_W-1:0]       vpn_q;
  logic [PAGE_BITS-1:0]   off_q;
  logic [TLB_IDX_W-1:0]   fill_idx;
  logic [XLEN-1:0]        pte_offset;

  assign vpn      = vaddr[XLEN-1:PAGE_BITS];
  assign idx      = vpn[TLB_IDX_W-1:0];
  assign fill_idx = vpn_q[TLB_IDX_W-1:0];
  // A lookup during flush sees the cleared table
  assign hit = valid[idx] && (tag_mem[idx] == vpn[VPN_W-1:TLB_IDX_W]) && !flush;

  // Upper VPN bits ignored by the page table
  assign pte_offset = {{(XLEN-PT_INDEX_BITS-3){1'b0}}, vpn[PT_INDEX_BITS-1:0], 3'b000};
  assign req_valid  = lookup && !hit;
  assign req_addr   = ptbr + pte_offset;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid   <= '0;
      walking <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= lookup && hit;
      if (flush) begin
        valid <= '0;
      end
      if (lookup && !hit) begin
        walking <= 1'b1;
      end
      if (walking && resp_valid) begin
        walking         <= 1'b0;
        done            <= 1'b1;
        valid[fill_idx] <= resp_data.pte.valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lookup) begin
      vpn_q <= vpn;
      off_q <= vaddr[PAGE_BITS-1:0];
    end
    if (lookup && hit) begin
      paddr <= {{(XLEN-PPN_W-PAGE_BITS){1'b0}}, ppn_mem[idx], vaddr[PAGE_BITS-1:0]};
    end
    if (walking && resp_valid) begin
      tag_mem[fill_idx] <= vpn_q[VPN_W-1:TLB_IDX_W];
      ppn_mem[fill_idx] <= resp_data.pte.ppn;
      paddr <= {{(XLEN-PPN_W-PAGE_BITS){1'b0}}, resp_data.pte.ppn, off_q};
    end
  end

  a_one_walk: assert property (@(posedge clk) disable iff (reset) walking |-> !lookup);

endmodule

// File: dcache/dcache.sv
module dcache import mem_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              req,
  input  logic              we,
  input  logic [XLEN-1:0]   paddr,
  input  logic [XLEN-1:0]   wdata,
  input  logic [STRB_W-1:0] strb,
  output logic              done,
  output logic [XLEN-1:0]   rdata,
  output logic              req_valid,
  output logic              req_we,
  output logic [XLEN-1:0]   req_addr,
  output logic [XLEN-1:0]   req_wdata,
  output logic [STRB_W-1:0] req_strb,
  input  logic              resp_valid,
  input  mem_word_u         resp_data
);

  logic [CACHE_LINES-1:0] valid;
  logic [CACHE_TAG_W-1:0] tag_mem  [CACHE_LINES];
  logic [XLEN-1:0]        data_mem [CACHE_LINES];
  logic [CACHE_IDX_W-1:0] idx;
  logic [CACHE_TAG_W-1:0] tag;
  logic                   hit;
  logic                   rd_pend;
  logic                   wr_pend;
  logic [CACHE_IDX_W-1:0] idx_q;
  logic [CACHE_TAG_W-1:0] tag_q;
  logic                   hit_q;
  logic [XLEN-1:0]        wdata_q;
  logic [STRB_W-1:0]      strb_q;

  assign idx = paddr[LINE_OFF_W +: CACHE_IDX_W];
  assign tag = paddr[XLEN-1 -: CACHE_TAG_W];
  assign hit = valid[idx] && (tag_mem[idx] == tag);

  // Stores always go to memory, reads only on a miss
  assign req_valid = req && (we || !hit);
  assign req_we    = we;
  assign req_addr  = {paddr[XLEN-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
  assign req_wdata = wdata;
  assign req_strb  = we ? strb : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid   <= '0;
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= req && !we && hit;
      if (req && !we && !hit) begin
        rd_pend <= 1'b1;
      end
      if (req && we) begin
        wr_pend <= 1'b1;
      end
      if (rd_pend && resp_valid) begin
        rd_pend      <= 1'b0;
        done         <= 1'b1;
        valid[idx_q] <= 1'b1;  // Line filled
      end
      if (wr_pend && resp_valid) begin
        wr_pend <= 1'b0;
        done    <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      idx_q   <= idx;
      tag_q   <= tag;
      hit_q   <= hit;
      wdata_q <= wdata;
      strb_q  <= strb;
    end
    if (req && !we && hit) begin
      rdata <= data_mem[idx];
    end
    if (rd_pend && resp_valid) begin
      tag_mem[idx_q]  <= tag_q;
      data_mem[idx_q] <= resp_data.data;
      rdata           <= resp_data.data;
    end
    // No write allocate, so only a resident line is merged
    if (wr_pend && resp_valid && hit_q) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (strb_q[i]) begin
          data_mem[idx_q][8*i +: 8] <= wdata_q[8*i +: 8];
        end
      end
    end
  end

endmodule

// File: verilog/bus_arbiter.sv
module bus_arbiter import mem_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              tlb_req_valid,
  input  logic [XLEN-1:0]   tlb_req_addr,
  output logic              tlb_resp_valid,
  output mem_word_u         tlb_resp_data,
  input  logic              cache_req_valid,
  input  logic              cache_req_we,
  input  logic [XLEN-1:0]   cache_req_addr,
  input  logic [XLEN-1:0]   cache_req_wdata,
  input  logic [STRB_W-1:0] cache_req_strb,
  output logic              cache_resp_valid,
  output mem_word_u         cache_resp_data,
  output logic              bus_req_valid,
  output logic              bus_req_we,
  output logic [XLEN-1:0]   bus_req_addr,
  output logic [XLEN-1:0]   bus_req_wdata,
  output logic [STRB_W-1:0] bus_req_strb,
  input  logic              bus_resp_valid,
  input  mem_word_u         bus_resp_data
);

  logic busy;
  logic owner_tlb;

  // TLB wins a same cycle request
  assign bus_req_valid = tlb_req_valid || cache_req_valid;
  assign bus_req_we    = tlb_req_valid ? 1'b0 : cache_req_we;
  assign bus_req_addr  = tlb_req_valid ? tlb_req_addr : cache_req_addr;
  assign bus_req_wdata = tlb_req_valid ? '0 : cache_req_wdata;
  assign bus_req_strb  = tlb_req_valid ? '0 : cache_req_strb;

  assign tlb_resp_valid   = bus_resp_valid && busy && owner_tlb;
  assign cache_resp_valid = bus_resp_valid && busy && !owner_tlb;
  assign tlb_resp_data    = bus_resp_data;
  assign cache_resp_data  = bus_resp_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      owner_tlb <= 1'b0;
    end else if (bus_req_valid) begin
      busy      <= 1'b1;
      owner_tlb <= tlb_req_valid;
    end else if (bus_resp_valid) begin
      busy <= 1'b0;
    end
  end

  a_single_txn: assert property (@(posedge clk) disable iff (reset) busy |-> !bus_req_valid);

endmodule

// File: verilog/mem_top.sv
module mem_top import mem_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic [XLEN-1:0]    ptbr,
  input  logic               flush,
  input  logic               in_valid,
  output logic               in_ready,
  input  logic [OP_W-1:0]    in_op,
  input  logic [XLEN-1:0]    in_addr,
  input  logic [XLEN-1:0]    in_wdata,
  input  logic [REGNO_W-1:0] in_rd_regno,
  input  logic               in_update_rd,
  output logic               out_valid,
  output logic [XLEN-1:0]    out_mdata,
  output logic [REGNO_W-1:0] out_rd_regno,
  output logic               out_update_rd,
  output logic               bus_req_valid,
  output logic               bus_req_we,
  output logic [XLEN-1:0]    bus_req_addr,
  output logic [XLEN-1:0]    bus_req_wdata,
  output logic [STRB_W-1:0]  bus_req_strb,
  input  logic               bus_resp_valid,
  input  mem_word_u          bus_resp_data
);

  logic              tlb_lookup;
  logic [XLEN-1:0]   tlb_vaddr;
  logic              tlb_done;
  logic [XLEN-1:0]   tlb_paddr;
  logic              cache_req;
  logic              cache_we;
  logic [XLEN-1:0]   cache_paddr;
  logic [XLEN-1:0]   cache_wdata;
  logic [STRB_W-1:0] cache_strb;
  logic              cache_done;
  logic [XLEN-1:0]   cache_rdata;
  logic              tlb_req_valid;
  logic [XLEN-1:0]   tlb_req_addr;
  logic              tlb_resp_valid;
  mem_word_u         tlb_resp_data;
  logic              cache_req_valid;
  logic              cache_req_we;
  logic [XLEN-1:0]   cache_req_addr;
  logic [XLEN-1:0]   cache_req_wdata;
  logic [STRB_W-1:0] cache_req_strb;
  logic              cache_resp_valid;
  mem_word_u         cache_resp_data;

  mem_stage u_stage (
    .clk           (clk),
    .reset         (reset),
    .flush         (flush),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_op         (in_op),
    .in_addr       (in_addr),
    .in_wdata      (in_wdata),
    .in_rd_regno   (in_rd_regno),
    .in_update_rd  (in_update_rd),
    .out_valid     (out_valid),
    .out_mdata     (out_mdata),
    .out_rd_regno  (out_rd_regno),
    .out_update_rd (out_update_rd),
    .tlb_lookup    (tlb_lookup),
    .tlb_vaddr     (tlb_vaddr),
    .tlb_done      (tlb_done),
    .tlb_paddr     (tlb_paddr),
    .cache_req     (cache_req),
    .cache_we      (cache_we),
    .cache_paddr   (cache_paddr),
    .cache_wdata   (cache_wdata),
    .cache_strb    (cache_strb),
    .cache_done    (cache_done),
    .cache_rdata   (cache_rdata)
  );

  dtlb u_dtlb (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .ptbr       (ptbr),
    .lookup     (tlb_lookup),
    .vaddr      (tlb_vaddr),
    .done       (tlb_done),
    .paddr      (tlb_paddr),
    .req_valid  (tlb_req_valid),
    .req_addr   (tlb_req_addr),
    .resp_valid (tlb_resp_valid),
    .resp_data  (tlb_resp_data)
  );

  dcache u_dcache (
    .clk        (clk),
    .reset      (reset),
    .req        (cache_req),
    .we         (cache_we),
    .paddr      (cache_paddr),
    .wdata      (cache_wdata),
    .strb       (cache_strb),
    .done       (cache_done),
    .rdata      (cache_rdata),
    .req_valid  (cache_req_valid),
    .req_we     (cache_req_we),
    .req_addr   (cache_req_addr),
    .req_wdata  (cache_req_wdata),
    .req_strb   (cache_req_strb),
    .resp_valid (cache_resp_valid),
    .resp_data  (cache_resp_data)
  );

  bus_arbiter u_arbiter (
    .clk              (clk),
    .reset            (reset),
    .tlb_req_valid    (tlb_req_valid),
    .tlb_req_addr     (tlb_req_addr),
    .tlb_resp_valid   (tlb_resp_valid),
    .tlb_resp_data    (tlb_resp_data),
    .cache_req_valid  (cache_req_valid),
    .cache_req_we     (cache_req_we),
    .cache_req_addr   (cache_req_addr),
    .cache_req_wdata  (cache_req_wdata),
    .cache_req_strb   (cache_req_strb),
    .cache_resp_valid (cache_resp_valid),
    .cache_resp_data  (cache_resp_data),
    .bus_req_valid    (bus_req_valid),
    .bus_req_we       (bus_req_we),
    .bus_req_addr     (bus_req_addr),
    .bus_req_wdata    (bus_req_wdata),
    .bus_req_strb     (bus_req_strb),
    .bus_resp_valid   (bus_resp_valid),
    .bus_resp_data    (bus_resp_data)
  );

endmodule

// File: dv/mem_model.sv
module mem_model import mem_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [XLEN-1:0]   ptbr,
  input  logic              bus_req_valid,
  input  logic              bus_req_we,
  input  logic [XLEN-1:0]   bus_req_addr,
  input  logic [XLEN-1:0]   bus_req_wdata,
  input  logic [STRB_W-1:0] bus_req_strb,
  output logic              bus_resp_valid,
  output mem_word_u         bus_resp_data
);

  logic [XLEN-1:0] mem [bit [XLEN-4:0]];  // Keyed by doubleword address
  integer          seed = 32'he778_a307;
  int              pt_reads;
  int              all_reads;
  int              req_count;
  logic            pending;
  int              wait_cnt;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] word;

  task automatic write_word(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
    mem[addr[XLEN-1:3]] = data;
  endtask

  function automatic logic [XLEN-1:0] read_word(input logic [XLEN-1:0] addr);
    if (mem.exists(addr[XLEN-1:3])) begin
      return mem[addr[XLEN-1:3]];
    end
    return '0;
  endfunction

  initial begin
    bus_resp_valid = 1'b0;
    bus_resp_data  = '0;
  end

  always @(posedge clk) begin
    if (reset) begin
      pending        <= 1'b0;
      bus_resp_valid <= 1'b0;
    end else begin
      bus_resp_valid <= 1'b0;
      if (bus_req_valid) begin
        pending   <= 1'b1;
        addr_q    <= bus_req_addr;
        wait_cnt  <= $unsigned($random(seed)) % 4;  // Latency of 1 to 4 cycles
        req_count = req_count + 1;
        if (bus_req_we) begin
          word = read_word(bus_req_addr);
          for (int i = 0; i < STRB_W; i++) begin
            if (bus_req_strb[i]) begin
              word[8*i +: 8] = bus_req_wdata[8*i +: 8];
            end
          end
          write_word(bus_req_addr, word);
        end else begin
          all_reads = all_reads + 1;
          if (bus_req_addr >= ptbr && bus_req_addr < ptbr + (8 << PT_INDEX_BITS)) begin
            pt_reads = pt_reads + 1;  // Page table region
          end
        end
      end else if (pending && wait_cnt == 0) begin
        pending            <= 1'b0;
        bus_resp_valid     <= 1'b1;
        bus_resp_data.data <= read_word(addr_q);
      end else if (pending) begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule

// File: dv/tb_mem_top.sv
module tb_mem_top import mem_pkg::*; ();

  localparam logic [XLEN-1:0]  PT_BASE = 64'h0000_0000_0010_0000;
  localparam logic [VPN_W-1:0] VPN_A   = 52'h10;
  localparam logic [VPN_W-1:0] VPN_B   = 52'h11;
  localparam logic [VPN_W-1:0] VPN_C   = 52'h7_0c12;  // Upper bits beyond the PT index
  localparam logic [PPN_W-1:0] PPN_NEW = 44'h3a0;
  localparam int               NUM_OPS = 105;

  logic               clk;
  logic               reset;
  logic [XLEN-1:0]    ptbr;
  logic               flush;
  logic               in_valid;
  logic               in_ready;
  logic [OP_W-1:0]    in_op;
  logic [XLEN-1:0]    in_addr;
  logic [XLEN-1:0]    in_wdata;
  logic [REGNO_W-1:0] in_rd_regno;
  logic               in_update_rd;
  logic               out_valid;
  logic [XLEN-1:0]    out_mdata;
  logic [REGNO_W-1:0] out_rd_regno;
  logic               out_update_rd;
  logic               bus_req_valid;
  logic               bus_req_we;
  logic [XLEN-1:0]    bus_req_addr;
  logic [XLEN-1:0]    bus_req_wdata;
  logic [STRB_W-1:0]  bus_req_strb;
  logic               bus_resp_valid;
  mem_word_u          bus_resp_data;

  integer             seed = 32'he778_a307;
  logic [PPN_W-1:0]   shadow_pt [int];
  logic [XLEN-1:0]    shadow_mem [bit [XLEN-4:0]];
  string              exp_name [$];
  logic [XLEN-1:0]    exp_mdata [$];
  logic [REGNO_W-1:0] exp_regno [$];
  logic               exp_update [$];
  string              cur_test;
  int                 checks;
  int                 errors;
  int                 done_count;
  int                 test_count;
  int                 test_checks;
  int                 test_errors;

  mem_top UUT (.*);

  mem_model u_mem (.*);

  always #10 clk = ~clk;

  function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] pa);
    return {pa[31:0], pa[63:32]} ^ (pa * 64'h9e37_79b9_7f4a_7c15);
  endfunction

  function automatic logic [XLEN-1:0] va_of(input logic [VPN_W-1:0] vpn, input int off);
    return {vpn, off[PAGE_BITS-1:0]};
  endfunction

  function automatic logic [XLEN-1:0] translate(input logic [XLEN-1:0] va);
    logic [XLEN-1:0] pa;
    pa = '0;
    pa[PAGE_BITS +: PPN_W] = shadow_pt[int'(va[PAGE_BITS +: PT_INDEX_BITS])];
    pa[PAGE_BITS-1:0]      = va[PAGE_BITS-1:0];
    return pa;
  endfunction

  function automatic logic [XLEN-1:0] ref_load(input logic [OP_W-1:0] op,
                                               input logic [XLEN-1:0] va);
    logic [XLEN-1:0] pa;
    logic [XLEN-1:0] dw;
    int              off;
    logic [7:0]      b;
    logic [15:0]     h;
    logic [31:0]     w;
    pa  = translate(va);
    dw  = shadow_mem[pa[XLEN-1:3]];
    off = va[2:0];
    b   = dw[8*off +: 8];
    h   = dw[16*(off/2) +: 16];  // Natural alignment
    w   = dw[32*(off/4) +: 32];
    case (op)
      OP_LB:   return {{(XLEN-8){b[7]}}, b};
      OP_LBU:  return {{(XLEN-8){1'b0}}, b};
      OP_LH:   return {{(XLEN-16){h[15]}}, h};
      OP_LHU:  return {{(XLEN-16){1'b0}}, h};
      OP_LW:   return {{(XLEN-32){w[31]}}, w};
      OP_LWU:  return {{(XLEN-32){1'b0}}, w};
      OP_LD:   return dw;
      default: return '0;
    endcase
  endfunction

  task automatic shadow_store(input logic [OP_W-1:0] op, input logic [XLEN-1:0] va,
                              input logic [XLEN-1:0] wd);
    logic [XLEN-1:0] pa;
    logic [XLEN-1:0] dw;
    int              off;
    pa  = translate(va);
    dw  = shadow_mem[pa[XLEN-1:3]];
    off = va[2:0];
    case (op)
      OP_SB:   dw[8*off +: 8] = wd[7:0];
      OP_SH:   dw[16*(off/2) +: 16] = wd[15:0];
      OP_SW:   dw[32*(off/4) +: 32] = wd[31:0];
      default: dw = wd;
    endcase
    shadow_mem[pa[XLEN-1:3]] = dw;
  endtask

  task automatic preload_page(input logic [PPN_W-1:0] ppn);
    logic [XLEN-1:0] pa;
    for (int i = 0; i < 64; i++) begin
      pa = {ppn, 12'h000} + 8 * i;
      shadow_mem[pa[XLEN-1:3]] = fill_word(pa);
      u_mem.write_word(pa, fill_word(pa));
    end
  endtask

  task automatic set_pte(input logic [VPN_W-1:0] vpn, input logic [PPN_W-1:0] ppn);
    mem_word_u pte;
    pte           = '0;
    pte.pte.valid = 1'b1;
    pte.pte.ppn   = ppn;
    shadow_pt[int'(vpn[PT_INDEX_BITS-1:0])] = ppn;
    u_mem.write_word(PT_BASE + 8 * vpn[PT_INDEX_BITS-1:0], pte.data);
  endtask

  task automatic check_mdata(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_regno(input string name, input logic [REGNO_W-1:0] exp,
                             input logic [REGNO_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s regno: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s flag: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("** Error %s bus reads: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_checks = checks;
    test_errors = errors;
    test_count++;
  endtask

  task automatic end_test();
    $display("%-16s %0d checks, %0d errors", cur_test, checks - test_checks,
             errors - test_errors);
  endtask

  // Called right after a falling edge and returns once the result was compared
  task automatic run_op(input logic [OP_W-1:0] op, input logic [XLEN-1:0] va,
                        input logic [XLEN-1:0] wd);
    int target;
    target = done_count + 1;
    if (op inside {OP_SB, OP_SH, OP_SW, OP_SD}) begin
      shadow_store(op, va, wd);
    end
    if (op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWU, OP_LD}) begin
      exp_mdata.push_back(ref_load(op, va));
    end else begin
      exp_mdata.push_back('0);
    end
    in_valid     = 1'b1;
    in_op        = op;
    in_addr      = va;
    in_wdata     = wd;
    in_rd_regno  = $random(seed);
    in_update_rd = $random(seed);
    exp_regno.push_back(in_rd_regno);
    exp_update.push_back(in_update_rd);
    exp_name.push_back($sformatf("%s op %0d addr %h", cur_test, op, va));
    while (!in_ready) @(negedge clk);
    @(negedge clk);
    in_valid = 1'b0;
    while (done_count < target) @(negedge clk);
  endtask

  task automatic probe_dword(input logic [XLEN-1:0] va, input logic [OP_W-1:0] ld_op);
    run_op(OP_LD, {va[XLEN-1:3], 3'b000}, '0);
    run_op(ld_op, va, '0);
    run_op(OP_LBU, {va[XLEN-1:3], va[2:0] + 3'd1}, '0);
    run_op(OP_LB, {va[XLEN-1:3], va[2:0] - 3'd1}, '0);
  endtask

  always @(posedge clk) begin : compare
    string           name;
    logic [XLEN-1:0] mdata;
    if (!reset && out_valid === 1'b1) begin
      if (exp_mdata.size() == 0) begin
        $display("Unexpected out_valid with no operation outstanding");
        errors++;
      end else begin
        name  = exp_name.pop_front();
        mdata = exp_mdata.pop_front();
        check_mdata(name, mdata, out_mdata);
        check_regno(name, exp_regno.pop_front(), out_rd_regno);
        check_flag(name, exp_update.pop_front(), out_update_rd);
      end
      done_count++;
    end
  end

  initial begin : watchdog
    repeat (16 + NUM_OPS * 40) @(posedge clk);
    $display("Watchdog expired in %s after %0d of %0d operations", cur_test, done_count,
             NUM_OPS);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : main
    logic [OP_W-1:0] st_op;
    logic [XLEN-1:0] va;
    int              cnt0;
    clk          = 1'b0;
    reset        = 1'b1;
    ptbr         = PT_BASE;
    flush        = 1'b0;
    in_valid     = 1'b0;
    in_op        = OP_NONE;
    in_addr      = '0;
    in_wdata     = '0;
    in_rd_regno  = '0;
    in_update_rd = 1'b0;
    preload_page(44'h300);
    preload_page(44'h301);
    preload_page(44'h302);
    preload_page(PPN_NEW);
    set_pte(VPN_A, 44'h300);
    set_pte(VPN_B, 44'h301);
    set_pte(VPN_C, 44'h302);
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    start_test("reset_idle");
    repeat (4) begin
      @(negedge clk);
      check_flag(cur_test, 1'b1, in_ready);
      check_flag(cur_test, 1'b0, out_valid);
      check_flag(cur_test, 1'b0, bus_req_valid);
    end
    end_test();

    start_test("load_offsets");
    for (int op = OP_LB; op <= OP_LD; op++) begin
      for (int off = 0; off < 8; off++) begin
        va = va_of(op[0] ? VPN_A : VPN_B, 8 * ($unsigned($random(seed)) % 64) + off);
        run_op(op, va, '0);
      end
    end
    end_test();

    start_test("store_merge");
    for (int w = 0; w < 4; w++) begin
      st_op = OP_SB + w;
      va    = va_of(VPN_B, 8 * (40 + w) + $unsigned($random(seed)) % 8);
      run_op(OP_LD, va, '0);  // Line now resident
      run_op(st_op, va, {$random(seed), $random(seed)});
      probe_dword(va, OP_LB + 2 * w);
      va = va_of(VPN_C, 8 * (40 + w) + $unsigned($random(seed)) % 8);
      run_op(st_op, va, {$random(seed), $random(seed)});
      probe_dword(va, OP_LB + 2 * w);
    end
    end_test();

    start_test("tlb_cache_reuse");
    run_op(OP_LD, va_of(VPN_A, 8 * 20), '0);
    cnt0 = u_mem.pt_reads;
    run_op(OP_LW, va_of(VPN_A, 8 * 21 + 4), '0);
    check_count({cur_test, " page walk"}, 0, u_mem.pt_reads - cnt0);
    cnt0 = u_mem.all_reads;
    run_op(OP_LHU, va_of(VPN_A, 8 * 21 + 2), '0);
    check_count({cur_test, " repeat"}, 0, u_mem.all_reads - cnt0);
    end_test();

    start_test("flush_remap");
    set_pte(VPN_A, PPN_NEW);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    cnt0  = u_mem.pt_reads;
    run_op(OP_LD, va_of(VPN_A, 8 * 21), '0);
    check_count(cur_test, 1, u_mem.pt_reads - cnt0);
    end_test();

    start_test("op_none");
    cnt0 = u_mem.req_count;
    run_op(OP_NONE, va_of(VPN_B, 8), 64'hffff_ffff_ffff_ffff);
    check_count(cur_test, 0, u_mem.req_count - cnt0);
    end_test();

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
common/mem_pkg.sv
mem_stage/lsu_align.sv
mem_stage/mem_stage.sv
dtlb/dtlb.sv
dcache/dcache.sv
verilog/bus_arbiter.sv
verilog/mem_top.sv
dv/mem_model.sv
dv/tb_mem_top.sv

// File: Bender.yml
package:
  name: mem_access_stage

sources:
  - common/mem_pkg.sv
  - mem_stage/lsu_align.sv
  - mem_stage/mem_stage.sv
  - dtlb/dtlb.sv
  - dcache/dcache.sv
  - verilog/bus_arbiter.sv
  - verilog/mem_top.sv
  - target: test
    files:
      - dv/mem_model.sv
      - dv/tb_mem_top.sv
